// File: rtl/exec_pkg.sv
package exec_pkg;

    // widths
    localparam int LEN_WORD         = 32;
    localparam int LEN_PREG_ADDR    = 6;
    localparam int LEN_CONTEXT      = 4;
    localparam int LEN_MEMDATA_ADDR = 12;

    // lanes into the stage
    localparam int EXECUTE_PARA = 4;
    localparam int EX_BRC       = 0;
    localparam int EX_MEM       = 1;
    localparam int EX_JMP       = 2;
    localparam int EX_OTH       = 3;

    // register write ports
    localparam int WRITE_PARA = 3;
    localparam int WR_MEM     = 0;
    localparam int WR_JMP     = 1;
    localparam int WR_OTH     = 2;

    typedef logic [LEN_WORD-1:0] word_t;

    // func3 of the conditional branches
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_op_e;

    // {func7[5], func3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    // load func3 codes
    // stores look at the low two bits only
    typedef enum logic [2:0] {
        MEM_LB  = 3'b000,
        MEM_LH  = 3'b001,
        MEM_LW  = 3'b010,
        MEM_LBU = 3'b100,
        MEM_LHU = 3'b101
    } mem_size_e;

    typedef struct packed {
        logic                     is_store;
        logic [2:0]               func3;
        logic [6:0]               func7;
        logic [LEN_PREG_ADDR-1:0] pa_rd;
        word_t                    rs1;
        word_t                    rs2;
        // branch context tag
        logic [LEN_CONTEXT-1:0]   ctx;
    } exec_info_t;

    typedef struct packed {
        logic                     valid;
        logic [LEN_PREG_ADDR-1:0] pa_rd;
        word_t                    data;
    } write_d_r_t;

    typedef struct packed {
        logic                   jump;
        word_t                  next_pc;
        logic                   branch;
        logic [LEN_CONTEXT-1:0] branch_context;
        // set when the branch is taken
        logic                   branch_hazard;
    } j_b_info_t;

endpackage

// File: rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic [2:0]      func3,
    input  exec_pkg::word_t rs1,
    input  exec_pkg::word_t rs2,
    output logic            taken
);
    import exec_pkg::*;

    branch_op_e op;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign op   = branch_op_e'(func3);
    assign eq   = (rs1 == rs2);
    assign lt_s = ($signed(rs1) < $signed(rs2));
    assign lt_u = (rs1 < rs2);

    always_comb begin
        case (op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            // 010 and 011 are not branches
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 order,
    output logic                 accepted,
    input  exec_pkg::exec_info_t info,
    output exec_pkg::write_d_r_t result
);
    import exec_pkg::*;

    alu_op_e                  op;
    logic                     alt;
    logic [4:0]               shamt;
    word_t                    alu_out;
    logic                     valid_q;
    logic [LEN_PREG_ADDR-1:0] pa_rd_q;
    word_t                    data_q;

    // func7[5] only selects sub and sra
    assign alt   = info.func7[5] && (info.func3 == 3'b000 || info.func3 == 3'b101);
    assign op    = alu_op_e'({alt, info.func3});
    assign shamt = info.rs2[4:0];

    // valid_q marks the result in flight; it leaves on the write port
    // the next cycle, so the ALU is idle again every cycle
    assign accepted = order;

    always_comb begin
        case (op)
            ALU_ADD:  alu_out = info.rs1 + info.rs2;
            ALU_SUB:  alu_out = info.rs1 - info.rs2;
            ALU_SLL:  alu_out = info.rs1 << shamt;
            ALU_SLT:  alu_out = word_t'($signed(info.rs1) < $signed(info.rs2));
            ALU_SLTU: alu_out = word_t'(info.rs1 < info.rs2);
            ALU_XOR:  alu_out = info.rs1 ^ info.rs2;
            ALU_SRL:  alu_out = info.rs1 >> shamt;
            ALU_SRA:  alu_out = word_t'($signed(info.rs1) >>> shamt);
            ALU_OR:   alu_out = info.rs1 | info.rs2;
            ALU_AND:  alu_out = info.rs1 & info.rs2;
            default:  alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= order && accepted;
        end
    end

    always_ff @(posedge clk) begin
        if (order && accepted) begin
            data_q  <= alu_out;
            pa_rd_q <= info.pa_rd;
        end
    end

    assign result.valid = valid_q;
    assign result.pa_rd = pa_rd_q;
    assign result.data  = data_q;

endmodule

// File: rtl/mem_unit.sv
`timescale 1ns/1ps

module mem_unit (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  order,
    output logic                                  accepted,
    input  exec_pkg::exec_info_t                  info,
    output exec_pkg::write_d_r_t                  result,
    output logic [exec_pkg::LEN_MEMDATA_ADDR-1:0] mem_a,
    output exec_pkg::word_t                       mem_sd,
    input  exec_pkg::word_t                       mem_ld,
    output logic [3:0]                            mem_write,
    output logic                                  mem_en
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        LOAD_RETURN
    } state_e;

    state_e     state;
    exec_info_t req;
    logic [1:0] offset;
    mem_size_e  ld_size;
    word_t      byte_sel;
    logic [15:0] half_sel;

    assign accepted = order && (state == IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (order) begin
                        state <= ACCESS;
                    end
                end
                // stores finish here, loads wait for mem_ld
                ACCESS:      state <= req.is_store ? IDLE : LOAD_RETURN;
                LOAD_RETURN: state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            req <= info;
        end
    end

    assign offset = req.rs1[1:0];
    assign mem_a  = req.rs1[LEN_MEMDATA_ADDR+1:2];
    assign mem_en = (state == ACCESS);

    // replicate store data over the lanes, strobe picks the bytes
    always_comb begin
        case (req.func3[1:0])
            2'b00: begin
                mem_sd    = {4{req.rs2[7:0]}};
                mem_write = 4'b0001 << offset;
            end
            2'b01: begin
                mem_sd    = {2{req.rs2[15:0]}};
                mem_write = 4'b0011 << {offset[1], 1'b0};
            end
            default: begin
                mem_sd    = req.rs2;
                mem_write = 4'b1111;
            end
        endcase
        if (!(mem_en && req.is_store)) begin
            mem_write = 4'b0000;
        end
    end

    assign ld_size  = mem_size_e'(req.func3);
    assign byte_sel = mem_ld >> {offset, 3'b000};
    assign half_sel = offset[1] ? mem_ld[31:16] : mem_ld[15:0];

    always_comb begin
        result.valid = (state == LOAD_RETURN);
        result.pa_rd = req.pa_rd;
        case (ld_size)
            MEM_LB:  result.data = {{(LEN_WORD-8){byte_sel[7]}}, byte_sel[7:0]};
            MEM_LBU: result.data = {{(LEN_WORD-8){1'b0}}, byte_sel[7:0]};
            MEM_LH:  result.data = {{(LEN_WORD-16){half_sel[15]}}, half_sel};
            MEM_LHU: result.data = {{(LEN_WORD-16){1'b0}}, half_sel};
            default: result.data = mem_ld;
        endcase
    end

endmodule

// File: rtl/exec.sv
`timescale 1ns/1ps

module exec (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic [exec_pkg::EXECUTE_PARA-1:0]                  order,
    output logic [exec_pkg::EXECUTE_PARA-1:0]                  accepted,
    input  exec_pkg::exec_info_t [exec_pkg::EXECUTE_PARA-1:0]  exec_info,
    output exec_pkg::write_d_r_t [exec_pkg::WRITE_PARA-1:0]    write_d_r,
    output exec_pkg::j_b_info_t                                j_b_info,
    output logic [exec_pkg::LEN_MEMDATA_ADDR-1:0]              mem_a,
    output exec_pkg::word_t                                    mem_sd,
    input  exec_pkg::word_t                                    mem_ld,
    output logic [3:0]                                         mem_write,
    output logic                                               mem_en,
    output logic                                               busy_out
);
    import exec_pkg::*;

    logic       branch_taken;
    logic       mem_accepted;
    logic       alu_accepted;
    write_d_r_t mem_result;
    write_d_r_t alu_result;

    assign busy_out = |order;

    // branch lane
    branch_unit u_branch (
        .func3 (exec_info[EX_BRC].func3),
        .rs1   (exec_info[EX_BRC].rs1),
        .rs2   (exec_info[EX_BRC].rs2),
        .taken (branch_taken)
    );

    // memory lane
    mem_unit u_mem (
        .clk       (clk),
        .rst       (rst),
        .order     (order[EX_MEM]),
        .accepted  (mem_accepted),
        .info      (exec_info[EX_MEM]),
        .result    (mem_result),
        .mem_a     (mem_a),
        .mem_sd    (mem_sd),
        .mem_ld    (mem_ld),
        .mem_write (mem_write),
        .mem_en    (mem_en)
    );

    // integer ALU on the other lane
    alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .order    (order[EX_OTH]),
        .accepted (alu_accepted),
        .info     (exec_info[EX_OTH]),
        .result   (alu_result)
    );

    // branch and jump finish in the cycle they are offered
    always_comb begin
        accepted         = '0;
        accepted[EX_BRC] = order[EX_BRC];
        accepted[EX_MEM] = mem_accepted;
        accepted[EX_JMP] = order[EX_JMP];
        accepted[EX_OTH] = alu_accepted;
    end

    // jump target and link value come precomputed in rs1 and rs2
    always_comb begin
        write_d_r[WR_MEM]       = mem_result;
        write_d_r[WR_OTH]       = alu_result;
        write_d_r[WR_JMP].valid = order[EX_JMP];
        write_d_r[WR_JMP].pa_rd = exec_info[EX_JMP].pa_rd;
        write_d_r[WR_JMP].data  = exec_info[EX_JMP].rs2;
    end

    always_comb begin
        j_b_info.jump           = order[EX_JMP];
        j_b_info.next_pc        = exec_info[EX_JMP].rs1;
        j_b_info.branch         = order[EX_BRC];
        j_b_info.branch_context = exec_info[EX_BRC].ctx;
        j_b_info.branch_hazard  = order[EX_BRC] && branch_taken;
    end

endmodule

// File: sim/exec_checker.sv
`timescale 1ns/1ps

module exec_checker (
    input logic                                            clk,
    input logic                                            rst,
    input logic [exec_pkg::EXECUTE_PARA-1:0]               accepted,
    input exec_pkg::write_d_r_t [exec_pkg::WRITE_PARA-1:0] write_d_r,
    input exec_pkg::j_b_info_t                             j_b_info,
    input logic [3:0]                                      mem_write,
    input logic                                            mem_en,
    input logic                                            busy_out
);
    import exec_pkg::*;

    int fails = 0;

    // every write goes back to an accept on its lane
    alu_write_a: assert property (@(posedge clk) disable iff (rst)
        write_d_r[WR_OTH].valid |-> $past(accepted[EX_OTH]))
        else begin $error("alu write without accept"); fails++; end

    mem_write_a: assert property (@(posedge clk) disable iff (rst)
        write_d_r[WR_MEM].valid |-> $past(accepted[EX_MEM], 2))
        else begin $error("load write without accept"); fails++; end

    mem_en_gap_a: assert property (@(posedge clk) disable iff (rst)
        mem_en |=> !mem_en)
        else begin $error("mem_en high in two cycles in a row"); fails++; end

    // from the second reset cycle on
    reset_quiet_a: assert property (@(posedge clk)
        rst && $past(rst) |-> accepted == '0 && !mem_en && mem_write == 4'b0
            && !write_d_r[WR_MEM].valid && !write_d_r[WR_JMP].valid
            && !write_d_r[WR_OTH].valid && !j_b_info.jump && !j_b_info.branch && !busy_out)
        else begin $error("outputs active during reset"); fails++; end

endmodule

bind exec exec_checker u_checker (.*);

// File: sim/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;
    import exec_pkg::*;

    localparam int ACCEPT_TIMEOUT = 20;

    logic                                  clk;
    logic                                  rst;
    logic [EXECUTE_PARA-1:0]               order;
    logic [EXECUTE_PARA-1:0]               accepted;
    exec_info_t [EXECUTE_PARA-1:0]         exec_info;
    write_d_r_t [WRITE_PARA-1:0]           write_d_r;
    j_b_info_t                             j_b_info;
    logic [LEN_MEMDATA_ADDR-1:0]           mem_a;
    word_t                                 mem_sd;
    word_t                                 mem_ld;
    logic [3:0]                            mem_write;
    logic                                  mem_en;
    logic                                  busy_out;

    word_t      mem_model [256];
    int         seed = 32'h9920c7a9;
    int         errors;
    int         tests;
    int         pa_cnt;
    int         lane_q [$];
    exec_info_t info_q [$];
    write_d_r_t w_q [$];
    j_b_info_t  jb_q [$];

    alu_op_e alu_ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                              ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
    logic [2:0] br_ops [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    // equal, less signed only, less unsigned only
    word_t pair_a [3] = '{32'd5, 32'hffff_fffd, 32'd2};
    word_t pair_b [3] = '{32'd5, 32'd2, 32'h8000_0000};

    exec dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // little endian data memory that answers one cycle after mem_en
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'hc3, i[7:0] + 8'h11};
        end
    end

    always @(posedge clk) begin
        if (mem_en) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_write[b]) begin
                    mem_model[mem_a[7:0]][8*b +: 8] <= mem_sd[8*b +: 8];
                end
            end
            mem_ld <= mem_model[mem_a[7:0]];
        end
    end

    function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic exec_info_t make_info(logic st, logic [2:0] f3, logic [6:0] f7,
                                             logic [LEN_PREG_ADDR-1:0] pa, word_t a,
                                             word_t b, logic [LEN_CONTEXT-1:0] ctx);
        return {st, f3, f7, pa, a, b, ctx};
    endfunction

    task automatic add_test(input int lane, input exec_info_t info, input write_d_r_t w,
                            input j_b_info_t jb);
        lane_q.push_back(lane);
        info_q.push_back(info);
        w_q.push_back(w);
        jb_q.push_back(jb);
    endtask

    task automatic add_alu(input alu_op_e op, input word_t a, input word_t b);
        logic [LEN_PREG_ADDR-1:0] pa;
        pa = pa_cnt[LEN_PREG_ADDR-1:0];
        pa_cnt++;
        add_test(EX_OTH, make_info(1'b0, op[2:0], op[3] ? 7'h20 : 7'h00, pa, a, b, 4'h0),
                 {1'b1, pa, ref_alu(op, a, b)}, '0);
    endtask

    // val is the store data, or the expected load result
    task automatic add_mem(input logic st, input logic [2:0] f3, input word_t addr,
                           input word_t val);
        logic [LEN_PREG_ADDR-1:0] pa;
        pa = pa_cnt[LEN_PREG_ADDR-1:0];
        pa_cnt++;
        if (st) begin
            add_test(EX_MEM, make_info(1'b1, f3, 7'h0, pa, addr, val, 4'h0), '0, '0);
        end else begin
            add_test(EX_MEM, make_info(1'b0, f3, 7'h0, pa, addr, 32'h0, 4'h0),
                     {1'b1, pa, val}, '0);
        end
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        logic [LEN_CONTEXT-1:0] ctx;
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 6; k++) begin
                ctx = LEN_CONTEXT'(p * 6 + k);
                add_test(EX_BRC, make_info(1'b0, br_ops[k], 7'h0, 6'd0, pair_a[p], pair_b[p], ctx),
                         '0, {1'b0, 32'h0, 1'b1, ctx, ref_taken(br_ops[k], pair_a[p], pair_b[p])});
            end
        end
        for (int k = 0; k < 10; k++) begin
            add_alu(alu_ops[k], $random(seed), $random(seed));
            add_alu(alu_ops[k], $random(seed), $random(seed));
            add_alu(alu_ops[k], 32'h8000_0000, 32'hffff_ffff);
            add_alu(alu_ops[k], 32'h7fff_ffff, 32'h0000_001f);
        end
        for (int k = 0; k < 2; k++) begin
            a = $random(seed);
            b = $random(seed);
            add_test(EX_JMP, make_info(1'b0, 3'b000, 7'h0, 6'(50 + k), a, b, 4'h0),
                     {1'b1, 6'(50 + k), b}, {1'b1, a, 1'b0, 4'h0, 1'b0});
        end
        add_mem(1'b1, 3'b010, 32'h40, 32'h8a7f_c3e1);
        add_mem(1'b0, 3'b000, 32'h40, 32'hffff_ffe1);
        add_mem(1'b0, 3'b000, 32'h43, 32'hffff_ff8a);
        add_mem(1'b0, 3'b100, 32'h41, 32'h0000_00c3);
        add_mem(1'b0, 3'b001, 32'h42, 32'hffff_8a7f);
        add_mem(1'b0, 3'b101, 32'h40, 32'h0000_c3e1);
        add_mem(1'b0, 3'b010, 32'h40, 32'h8a7f_c3e1);
        add_mem(1'b1, 3'b010, 32'h44, 32'hdead_beef);
        add_mem(1'b1, 3'b001, 32'h46, 32'h0000_5a6b);
        add_mem(1'b1, 3'b000, 32'h45, 32'h0000_0099);
        add_mem(1'b0, 3'b010, 32'h44, 32'h5a6b_99ef);
        add_mem(1'b0, 3'b101, 32'h44, 32'h0000_99ef);
    endtask

    task automatic check_write(input write_d_r_t got, input write_d_r_t exp, input string what);
        if (got.valid !== exp.valid
                || (exp.valid && {got.pa_rd, got.data} !== {exp.pa_rd, exp.data})) begin
            $display("[FAIL] %0t ns: %s write got %0b/%0d/%h, expected %0b/%0d/%h", $time, what,
                     got.valid, got.pa_rd, got.data, exp.valid, exp.pa_rd, exp.data);
            errors++;
        end
    endtask

    task automatic check_jb(input j_b_info_t got, input j_b_info_t exp, input string what);
        if (got.jump !== exp.jump || got.branch !== exp.branch
                || (exp.jump && got.next_pc !== exp.next_pc)
                || (exp.branch && {got.branch_context, got.branch_hazard}
                    !== {exp.branch_context, exp.branch_hazard})) begin
            $display("[FAIL] %0t ns: %s report got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_accept(input int lane);
        int waited;
        waited = 0;
        while (!accepted[lane] && waited < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!accepted[lane]) begin
            $display("timeout: order on lane %0d was not accepted within %0d cycles", lane,
                     ACCEPT_TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_idle(input string when);
        int errs_before;
        errs_before = errors;
        check_flag(|accepted, 1'b0, {when, " accepted"});
        check_flag(write_d_r[WR_MEM].valid || write_d_r[WR_JMP].valid
                   || write_d_r[WR_OTH].valid, 1'b0, {when, " write valid"});
        check_flag(j_b_info.jump || j_b_info.branch, 1'b0, {when, " jump or branch"});
        check_flag(mem_en || (|mem_write), 1'b0, {when, " memory port"});
        check_flag(busy_out, 1'b0, {when, " busy_out"});
        tests++;
        $display("test idle %s: %s", when, errors == errs_before ? "ok" : "failed");
    endtask

    task automatic run_test(input int i);
        int lane;
        int errs_before;
        lane = lane_q[i];
        errs_before = errors;
        @(posedge clk);
        order[lane]     <= 1'b1;
        exec_info[lane] <= info_q[i];
        @(negedge clk);
        check_flag(busy_out, 1'b1, "busy_out with an order");
        wait_accept(lane);
        // branch and jump report in the accept cycle
        if (lane == EX_BRC || lane == EX_JMP) begin
            check_jb(j_b_info, jb_q[i], "jump/branch");
        end
        if (lane == EX_JMP) begin
            check_write(write_d_r[WR_JMP], w_q[i], "jump link");
        end
        @(posedge clk);
        order[lane] <= 1'b0;
        if (lane == EX_MEM) begin
            @(posedge clk);
            @(negedge clk);
            check_write(write_d_r[WR_MEM], w_q[i], "memory");
        end else if (lane == EX_OTH) begin
            @(negedge clk);
            check_write(write_d_r[WR_OTH], w_q[i], "alu");
        end
        tests++;
        $display("test %0d lane %0d: %s", i, lane, errors == errs_before ? "ok" : "failed");
    endtask

    // second memory order must wait while the ALU keeps accepting
    task automatic run_backpressure();
        exec_info_t ld_a;
        exec_info_t ld_b;
        exec_info_t op_a;
        exec_info_t op_b;
        int         errs_before;
        errs_before = errors;
        ld_a = make_info(1'b0, 3'b010, 7'h0, 6'd40, 32'h40, 32'h0, 4'h0);
        ld_b = make_info(1'b0, 3'b100, 7'h0, 6'd41, 32'h47, 32'h0, 4'h0);
        op_a = make_info(1'b0, 3'b000, 7'h0, 6'd42, 32'h1234_5678, 32'h1111_1111, 4'h0);
        op_b = make_info(1'b0, 3'b100, 7'h0, 6'd43, 32'hf0f0_0ff0, 32'h0ff0_f0f0, 4'h0);
        @(posedge clk);
        order[EX_MEM]     <= 1'b1;
        exec_info[EX_MEM] <= ld_a;
        order[EX_OTH]     <= 1'b1;
        exec_info[EX_OTH] <= op_a;
        @(negedge clk);
        check_flag(accepted[EX_MEM], 1'b1, "first memory accept");
        check_flag(accepted[EX_OTH], 1'b1, "first alu accept");
        @(posedge clk);
        exec_info[EX_MEM] <= ld_b;
        exec_info[EX_OTH] <= op_b;
        @(negedge clk);
        check_flag(accepted[EX_MEM], 1'b0, "second memory accept while busy");
        check_flag(accepted[EX_OTH], 1'b1, "alu accept while memory busy");
        check_write(write_d_r[WR_OTH], {1'b1, 6'd42, ref_alu(ALU_ADD, op_a.rs1, op_a.rs2)},
                    "first alu");
        @(posedge clk);
        order[EX_OTH] <= 1'b0;
        @(negedge clk);
        check_flag(accepted[EX_MEM], 1'b0, "second memory accept during load return");
        check_write(write_d_r[WR_MEM], {1'b1, 6'd40, 32'h8a7f_c3e1}, "first load");
        check_write(write_d_r[WR_OTH], {1'b1, 6'd43, ref_alu(ALU_XOR, op_b.rs1, op_b.rs2)},
                    "second alu");
        wait_accept(EX_MEM);
        @(posedge clk);
        order[EX_MEM] <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_write(write_d_r[WR_MEM], {1'b1, 6'd41, 32'h0000_005a}, "second load");
        tests++;
        $display("test back-pressure: %s", errors == errs_before ? "ok" : "failed");
    endtask

    initial begin
        rst       = 1'b1;
        order     = '0;
        exec_info = '0;
        mem_ld    = '0;
        errors    = 0;
        tests     = 0;
        pa_cnt    = 1;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_idle("during reset");
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle("after reset");
        for (int i = 0; i < lane_q.size(); i++) begin
            run_test(i);
        end
        run_backpressure();
        @(negedge clk);
        check_idle("with no order");
        errors += dut_i.u_checker.fails;
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/exec_pkg.sv
rtl/branch_unit.sv
rtl/alu.sv
rtl/mem_unit.sv
rtl/exec.sv
sim/exec_checker.sv
sim/exec_tb.sv

// File: Bender.yml
package:
  name: exec

sources:
  - files:
      - rtl/exec_pkg.sv
      - rtl/branch_unit.sv
      - rtl/alu.sv
      - rtl/mem_unit.sv
      - rtl/exec.sv
  - target: simulation
    files:
      - sim/exec_checker.sv
      - sim/exec_tb.sv
